// ==== hw/gprPkg.sv ====
//////////////////////////////
// Shared widths, register id codes and bundle types for the
// six-read, three-write register file. Referenced by scoped name
//////////////////////////////
package gprPkg;

	localparam int DataWidth = 64;	// Register and value width
	localparam int IdWidth = 6;
	localparam int ImmWidth = 33;	// Top bit is the sign
	localparam int NumRegs = 32;
	localparam int NumLanes = 3;	// Lanes A, B, C
	localparam int NumStages = 3;	// Execute stages forwarded from
	localparam int NumReadPorts = 6;	// Rs, Rt, Ru, Rv, Rx, Ry

	typedef logic [IdWidth-1:0] gprId_t;
	typedef logic [DataWidth-1:0] gprData_t;

	localparam gprId_t GprZzr = 6'h3E;	// Zero register
	localparam gprId_t GprImm = 6'h3F;	// Decode immediate

	// One lane result. Ids of 32 and up never write
	typedef struct packed {
		gprId_t id;
		gprData_t val;
	} gprWr_t;

	// All three lanes of one execute stage
	typedef struct packed {
		gprWr_t laneA;
		gprWr_t laneB;
		gprWr_t laneC;
	} gprStage_t;

	// Where a read port takes its value from
	typedef enum logic [1:0] {
		SrcReg,
		SrcImm,
		SrcZero
	} gprSrc_e;

	// Winning write lane for one register
	typedef enum logic [1:0] {
		LaneA,
		LaneB,
		LaneC
	} laneSel_e;

endpackage

// ==== hw/gprWriteDecode.sv ====
`timescale 1ns/1ps
//////////////////////////////
// Write decoder. Turns the three stage-3 lanes into one enable
// and one winning lane select per register
//////////////////////////////
module gprWriteDecode (
	input  logic hold,
	input  gprPkg::gprStage_t wrBundle,
	output logic [gprPkg::NumRegs-1:0] wrEn,
	output gprPkg::laneSel_e wrLane [gprPkg::NumRegs]
);

	logic [gprPkg::NumRegs-1:0] hitA;
	logic [gprPkg::NumRegs-1:0] hitB;
	logic [gprPkg::NumRegs-1:0] hitC;

	// Ids of 32 and up match no register, so they drop out here
	always_comb begin
		for (int r = 0; r < gprPkg::NumRegs; r++) begin
			hitA[r] = (wrBundle.laneA.id == gprPkg::gprId_t'(r));
			hitB[r] = (wrBundle.laneB.id == gprPkg::gprId_t'(r));
			hitC[r] = (wrBundle.laneC.id == gprPkg::gprId_t'(r));
		end
	end

	always_comb begin
		for (int r = 0; r < gprPkg::NumRegs; r++) begin
			wrEn[r] = (hitA[r] | hitB[r] | hitC[r]) & ~hold;
			if (hitA[r]) begin
				wrLane[r] = gprPkg::LaneA;	// A beats B and C
			end else if (hitB[r]) begin
				wrLane[r] = gprPkg::LaneB;
			end else begin
				wrLane[r] = gprPkg::LaneC;	// Also the idle default
			end
		end
	end

endmodule

// ==== hw/gprCell.sv ====
`timescale 1ns/1ps
//////////////////////////////
// One 64-bit register. Stores the selected lane value on the
// clock edge when enabled; hold arrives folded into the enable
//////////////////////////////
module gprCell #(
	parameter gprPkg::gprData_t RegResetValue = '0
) (
	input  logic clock,
	input  logic arstN,
	input  logic wrEn,
	input  gprPkg::laneSel_e wrLane,
	input  gprPkg::gprData_t laneVal [gprPkg::NumLanes],
	output gprPkg::gprData_t regVal
);

	gprPkg::gprData_t nextVal;

	always_comb begin
		case (wrLane)
			gprPkg::LaneA: nextVal = laneVal[0];
			gprPkg::LaneB: nextVal = laneVal[1];
			default: nextVal = laneVal[2];
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			regVal <= RegResetValue;
		end else if (wrEn) begin
			regVal <= nextVal;
		end
	end

	// Nothing but an enable may disturb the stored value
	property pStableWhenIdle;
		@(posedge clock) disable iff (!arstN)
		!wrEn |=> $stable(regVal);
	endproperty

	aStableWhenIdle: assert property (pStableWhenIdle)
		else $error("Register changed without a write enable");

endmodule

// ==== hw/gprReadPort.sv ====
`timescale 1ns/1ps
//////////////////////////////
// One combinational read port. Picks a register, the lane
// immediate or zero by id, then overlays in-flight results
//////////////////////////////
module gprReadPort (
	input  gprPkg::gprId_t rdId,
	input  logic [gprPkg::ImmWidth-1:0] imm,	// This port's lane immediate
	input  gprPkg::gprData_t regArray [gprPkg::NumRegs],
	input  gprPkg::gprStage_t stage1,	// Youngest
	input  gprPkg::gprStage_t stage2,
	input  gprPkg::gprStage_t stage3,	// Oldest, being written back
	output gprPkg::gprData_t rdVal
);

	localparam int IdxWidth = $clog2(gprPkg::NumRegs);
	localparam int ExtWidth = gprPkg::DataWidth - gprPkg::ImmWidth;

	gprPkg::gprSrc_e src;
	gprPkg::gprStage_t stages [gprPkg::NumStages];
	gprPkg::gprData_t baseVal;
	gprPkg::gprData_t fwdVal;
	logic fwdHit;

	assign stages[0] = stage1;
	assign stages[1] = stage2;
	assign stages[2] = stage3;

	// Source decode
	always_comb begin
		if (rdId < gprPkg::gprId_t'(gprPkg::NumRegs)) begin
			src = gprPkg::SrcReg;
		end else if (rdId == gprPkg::GprImm) begin
			src = gprPkg::SrcImm;
		end else begin
			src = gprPkg::SrcZero;	// GprZzr and unused codes
		end
	end

	always_comb begin
		case (src)
			gprPkg::SrcReg: begin
				baseVal = regArray[rdId[IdxWidth-1:0]];
			end
			gprPkg::SrcImm: begin
				baseVal = {{ExtWidth{imm[gprPkg::ImmWidth-1]}}, imm};	// Sign extend
			end
			default: begin
				baseVal = '0;
			end
		endcase
	end

	// Walk from stage 3 lane C up to stage 1 lane A.
	// Each later match overrides, so the youngest result wins
	always_comb begin
		fwdHit = 1'b0;
		fwdVal = '0;
		for (int s = gprPkg::NumStages - 1; s >= 0; s--) begin
			if (stages[s].laneC.id == rdId) begin
				fwdHit = 1'b1;
				fwdVal = stages[s].laneC.val;
			end
			if (stages[s].laneB.id == rdId) begin
				fwdHit = 1'b1;
				fwdVal = stages[s].laneB.val;
			end
			if (stages[s].laneA.id == rdId) begin
				fwdHit = 1'b1;
				fwdVal = stages[s].laneA.val;
			end
		end
	end

	// Immediates and zero codes never forward
	assign rdVal = (src == gprPkg::SrcReg && fwdHit) ? fwdVal : baseVal;

	always_comb begin
		if (src == gprPkg::SrcZero) begin
			assert final (rdVal == '0)
				else $error("Zero source read back %h", rdVal);
		end
	end

endmodule

// ==== hw/gprFile.sv ====
`timescale 1ns/1ps
//////////////////////////////
// Register file top. 32 x 64-bit registers, six combinational
// read ports with forwarding, writes taken from stage 3
//////////////////////////////
module gprFile #(
	parameter gprPkg::gprData_t RegResetValue = '0
) (
	input  logic clock,
	input  logic arstN,
	input  logic hold,	// Freezes all writes
	input  gprPkg::gprId_t rdId [gprPkg::NumReadPorts],
	input  logic [gprPkg::ImmWidth-1:0] immA,
	input  logic [gprPkg::ImmWidth-1:0] immB,
	input  logic [gprPkg::ImmWidth-1:0] immC,
	input  gprPkg::gprStage_t stage1,
	input  gprPkg::gprStage_t stage2,
	input  gprPkg::gprStage_t stage3,	// Also the writeback bundle
	output gprPkg::gprData_t rdVal [gprPkg::NumReadPorts]
);

	// Two read ports share each lane's immediate
	localparam int PortsPerLane = gprPkg::NumReadPorts / gprPkg::NumLanes;

	logic [gprPkg::NumRegs-1:0] wrEn;
	gprPkg::laneSel_e wrLane [gprPkg::NumRegs];
	gprPkg::gprData_t wrVal [gprPkg::NumLanes];
	gprPkg::gprData_t regArray [gprPkg::NumRegs];
	logic [gprPkg::ImmWidth-1:0] laneImm [gprPkg::NumLanes];

	assign wrVal[0] = stage3.laneA.val;
	assign wrVal[1] = stage3.laneB.val;
	assign wrVal[2] = stage3.laneC.val;

	assign laneImm[0] = immA;
	assign laneImm[1] = immB;
	assign laneImm[2] = immC;

	gprWriteDecode decode_i (
		.hold(hold),
		.wrBundle(stage3),
		.wrEn(wrEn),
		.wrLane(wrLane)
	);

	genvar r;
	generate
		for (r = 0; r < gprPkg::NumRegs; r++) begin : gCell
			gprCell #(
				.RegResetValue(RegResetValue)
			) cell_i (
				.clock(clock),
				.arstN(arstN),
				.wrEn(wrEn[r]),
				.wrLane(wrLane[r]),
				.laneVal(wrVal),
				.regVal(regArray[r])
			);
		end
	endgenerate

	genvar p;
	generate
		for (p = 0; p < gprPkg::NumReadPorts; p++) begin : gPort
			gprReadPort port_i (
				.rdId(rdId[p]),
				.imm(laneImm[p / PortsPerLane]),	// Ports 0-1 A, 2-3 B, 4-5 C
				.regArray(regArray),
				.stage1(stage1),
				.stage2(stage2),
				.stage3(stage3),
				.rdVal(rdVal[p])
			);
		end
	endgenerate

endmodule

// ==== verif/gprFileTests.svh ====
//////////////////////////////
// Directed tests and reference helpers, included in the
// testbench module body
//////////////////////////////
`ifndef GPR_FILE_TESTS_SVH
`define GPR_FILE_TESTS_SVH

function automatic gprPkg::gprWr_t makeWr(gprPkg::gprId_t id, gprPkg::gprData_t val);
	return gprPkg::gprWr_t'{id: id, val: val};
endfunction

function automatic gprPkg::gprStage_t packStage(gprPkg::gprWr_t a, gprPkg::gprWr_t b,
		gprPkg::gprWr_t c);
	return gprPkg::gprStage_t'{laneA: a, laneB: b, laneC: c};
endfunction

function automatic gprPkg::gprStage_t idleStage();
	return packStage(makeWr(gprPkg::GprZzr, '0), makeWr(gprPkg::GprZzr, '0),
		makeWr(gprPkg::GprZzr, '0));
endfunction

function automatic logic [gprPkg::ImmWidth-1:0] portImm(int p);
	case (p / 2)	// Two ports per lane
		0: return immA;
		1: return immB;
		default: return immC;
	endcase
endfunction

// Random low 32 bits under a chosen sign bit
function automatic logic [gprPkg::ImmWidth-1:0] randomImm(logic negative);
	logic [63:0] bits;
	bits = randomBits(32);
	return {negative, bits[31:0]};
endfunction

// First match from stage1 A down to stage3 C, else the shadow copy
function automatic gprPkg::gprData_t expectedRead(gprPkg::gprId_t id,
		logic [gprPkg::ImmWidth-1:0] imm, gprPkg::gprStage_t s1, gprPkg::gprStage_t s2,
		gprPkg::gprStage_t s3);
	gprPkg::gprWr_t slots [9];
	slots = '{s1.laneA, s1.laneB, s1.laneC, s2.laneA, s2.laneB, s2.laneC,
		s3.laneA, s3.laneB, s3.laneC};
	if (id == gprPkg::GprImm) return {{(gprPkg::DataWidth - gprPkg::ImmWidth){imm[32]}}, imm};
	if (id >= 32) return '0;
	foreach (slots[k]) begin
		if (slots[k].id == id) return slots[k].val;
	end
	return shadow[id[4:0]];
endfunction

// Lane A claims a register before B, B before C
function automatic void commitShadow(gprPkg::gprStage_t s3, logic holdVal);
	logic [31:0] taken;
	gprPkg::gprWr_t lanes [3];
	taken = '0;
	lanes = '{s3.laneA, s3.laneB, s3.laneC};
	if (holdVal) return;
	foreach (lanes[k]) begin
		if (lanes[k].id < 32 && !taken[lanes[k].id[4:0]]) begin
			shadow[lanes[k].id[4:0]] = lanes[k].val;
			taken[lanes[k].id[4:0]] = 1'b1;
		end
	end
endfunction

task automatic writeStage(gprPkg::gprStage_t s3);
	@(negedge clock);
	stage3 = s3;
	@(negedge clock);	// Rising edge in between stores it
	commitShadow(s3, hold);
	stage3 = idleStage();
endtask

task automatic checkPorts(gprPkg::gprId_t id, string tag);
	@(negedge clock);
	foreach (rdId[p]) rdId[p] = id;
	#2;
	for (int p = 0; p < gprPkg::NumReadPorts; p++) begin
		checkEqual(rdVal[p], expectedRead(id, portImm(p), stage1, stage2, stage3),
			$sformatf("%s port %0d id %0d", tag, p, id));
	end
endtask

task automatic resetReadsDefault();
	for (int r = 0; r < gprPkg::NumRegs; r++) checkPorts(gprPkg::gprId_t'(r), "reset");
endtask

task automatic writeThenReadBack();
	gprPkg::gprId_t ids [3];
	for (int base = 0; base < gprPkg::NumRegs; base += 3) begin
		for (int k = 0; k < 3; k++) begin
			ids[k] = (base + k < 32) ? gprPkg::gprId_t'(base + k) : gprPkg::GprZzr;
		end
		writeStage(packStage(makeWr(ids[0], randomBits(64)), makeWr(ids[1], randomBits(64)),
			makeWr(ids[2], randomBits(64))));
	end
	for (int r = 0; r < gprPkg::NumRegs; r++) checkPorts(gprPkg::gprId_t'(r), "readback");
	writeStage(packStage(makeWr(6'd7, randomBits(64)), makeWr(6'd7, randomBits(64)),
		makeWr(6'd7, randomBits(64))));	// A beats B and C
	checkPorts(6'd7, "priority A");
	writeStage(packStage(makeWr(6'd10, randomBits(64)), makeWr(6'd9, randomBits(64)),
		makeWr(6'd9, randomBits(64))));
	checkPorts(6'd9, "priority B");
	checkPorts(6'd10, "priority other");
endtask

task automatic holdBlocksWrites();
	gprPkg::gprStage_t s;
	s = packStage(makeWr(6'd3, randomBits(64)), makeWr(6'd4, randomBits(64)),
		makeWr(6'd5, randomBits(64)));
	@(negedge clock);
	hold = 1'b1;
	writeStage(s);
	for (int r = 3; r < 6; r++) checkPorts(gprPkg::gprId_t'(r), "held");
	@(negedge clock);
	hold = 1'b0;
	writeStage(s);
	for (int r = 3; r < 6; r++) checkPorts(gprPkg::gprId_t'(r), "released");
endtask

task automatic forwardByPriority();
	gprPkg::gprWr_t slots [9];
	gprPkg::gprData_t vals [9];
	foreach (vals[k]) vals[k] = randomBits(64);
	@(negedge clock);
	hold = 1'b1;	// Array frozen so only forwarding acts
	for (int k = 0; k <= 9; k++) begin
		foreach (slots[j]) slots[j] = makeWr((j >= k) ? 6'd12 : 6'd13, vals[j]);
		@(negedge clock);
		stage1 = packStage(slots[0], slots[1], slots[2]);
		stage2 = packStage(slots[3], slots[4], slots[5]);
		stage3 = packStage(slots[6], slots[7], slots[8]);
		checkPorts(6'd12, "forward");
		checkEqual(rdVal[0], (k < 9) ? vals[k] : shadow[12], $sformatf("forward slot %0d", k));
	end
	@(negedge clock);
	stage1 = idleStage();
	stage2 = idleStage();
	stage3 = idleStage();
	hold = 1'b0;
endtask

task automatic specialIdsRead();
	for (int sign = 0; sign < 2; sign++) begin
		@(negedge clock);
		immA = randomImm(sign == 1);
		immB = randomImm(sign == 1);
		immC = randomImm(sign == 1);
		stage1 = packStage(makeWr(gprPkg::GprImm, randomBits(64)), makeWr(gprPkg::GprZzr, '0),
			makeWr(gprPkg::GprZzr, '0));	// Must not forward
		checkPorts(gprPkg::GprImm, "immediate");
	end
	for (int id = 32; id < 63; id++) begin
		@(negedge clock);
		stage1 = packStage(makeWr(gprPkg::gprId_t'(id), randomBits(64)), makeWr(6'd0, '0),
			makeWr(6'd0, '0));
		stage3 = packStage(makeWr(gprPkg::GprZzr, '0), makeWr(gprPkg::GprZzr, '0),
			makeWr(gprPkg::gprId_t'(id), randomBits(64)));
		checkPorts(gprPkg::gprId_t'(id), "zero code");
		checkEqual(rdVal[5], '0, $sformatf("zero code %0d", id));
	end
	@(negedge clock);
	stage1 = idleStage();
	stage3 = idleStage();
endtask

`endif

// ==== verif/gprFileTb.sv ====
`timescale 1ns/1ps
//////////////////////////////
// Testbench for the register file. Clock, reset, LFSR stimulus,
// compare and watchdog here; directed tests come from the header
//////////////////////////////
module gprFileTb;

	localparam int Period = 20;
	localparam gprPkg::gprData_t ResetVal = 64'hA5A5_0F0F_5A5A_F0F0;
	localparam int ResetCycles = 16;
	// Cycles per test: reset, write, hold, forwarding, specials
	localparam int TestCycles = 32 + 70 + 20 + 25 + 70;
	localparam int WatchdogCycles = 2 * (ResetCycles + TestCycles) + 100;

	logic clock;
	logic arstN;
	logic hold;
	gprPkg::gprId_t rdId [gprPkg::NumReadPorts];
	logic [gprPkg::ImmWidth-1:0] immA;
	logic [gprPkg::ImmWidth-1:0] immB;
	logic [gprPkg::ImmWidth-1:0] immC;
	gprPkg::gprStage_t stage1;
	gprPkg::gprStage_t stage2;
	gprPkg::gprStage_t stage3;
	gprPkg::gprData_t rdVal [gprPkg::NumReadPorts];

	gprPkg::gprData_t shadow [gprPkg::NumRegs];	// Expected array contents
	logic [31:0] lfsrState;

	gprFile #(
		.RegResetValue(ResetVal)
	) dut_i (
		.clock(clock),
		.arstN(arstN),
		.hold(hold),
		.rdId(rdId),
		.immA(immA),
		.immB(immB),
		.immC(immC),
		.stage1(stage1),
		.stage2(stage2),
		.stage3(stage3),
		.rdVal(rdVal)
	);

	initial begin
		clock = 1'b0;
		forever #(Period / 2) clock = ~clock;
	end

	// Fibonacci LFSR with taps 32 22 2 1
	function logic stepLfsr();
		logic fb;
		fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
		lfsrState = {lfsrState[30:0], fb};
		return fb;
	endfunction

	function logic [63:0] randomBits(int n);
		logic [63:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[62:0], stepLfsr()};	// One step per bit
		end
		return val;
	endfunction

	task automatic checkEqual(gprPkg::gprData_t actual, gprPkg::gprData_t expected,
			string msg);
		if (actual !== expected) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, msg, actual, expected);
			$display("** FAIL **");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	`include "gprFileTests.svh"

	initial begin
		#(WatchdogCycles * Period);
		$display("Watchdog expired before the test sequence finished");
		$display("** FAIL **");
		$fatal(1, "Simulation timed out");
	end

	initial begin
		lfsrState = 32'h48f6_a3c1;
		arstN = 1'b0;
		hold = 1'b0;
		foreach (rdId[p]) rdId[p] = gprPkg::GprZzr;
		immA = '0;
		immB = '0;
		immC = '0;
		stage1 = idleStage();
		stage2 = idleStage();
		stage3 = idleStage();
		foreach (shadow[r]) shadow[r] = ResetVal;
		repeat (ResetCycles) @(posedge clock);
		@(negedge clock);
		arstN = 1'b1;
		resetReadsDefault();
		writeThenReadBack();
		holdBlocksWrites();
		forwardByPriority();
		specialIdsRead();
		$display("** PASS **");
		$finish;
	end

endmodule

// ==== gprFile.f ====
+incdir+verif
hw/gprPkg.sv
hw/gprWriteDecode.sv
hw/gprCell.sv
hw/gprReadPort.sv
hw/gprFile.sv
verif/gprFileTb.sv

// ==== Bender.yml ====
package:
  name: gprFile

sources:
  - hw/gprPkg.sv
  - hw/gprWriteDecode.sv
  - hw/gprCell.sv
  - hw/gprReadPort.sv
  - hw/gprFile.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/gprFileTb.sv
